// File: back_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module back_pipe (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire hz_pkg::dec_instr_t id_slot,
    input  wire logic               stall,
    output hz_pkg::dec_instr_t      ex_slot,
    output hz_pkg::dec_instr_t      mem_slot,
    output hz_pkg::retire_t         retire
);

    import hz_pkg::*;

    logic       ex_vld;
    logic       mem_vld;
    logic       wb_vld;
    dec_instr_t ex_q;
    dec_instr_t mem_q;
    dec_instr_t wb_q;

    // bubble into execute on stall, later slots always move
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_vld  <= 1'b0;
            mem_vld <= 1'b0;
            wb_vld  <= 1'b0;
        end else begin
            ex_vld  <= id_slot.valid && !stall;
            mem_vld <= ex_vld;
            wb_vld  <= mem_vld;
        end
    end

    always_ff @(posedge clk) begin
        ex_q  <= id_slot;
        mem_q <= ex_q;
        wb_q  <= mem_q;
    end

    always_comb begin
        ex_slot        = ex_q;
        ex_slot.valid  = ex_vld;
        mem_slot       = mem_q;
        mem_slot.valid = mem_vld;
    end

    // one retire pulse per instruction leaving writeback
    always_comb begin
        retire.valid     = wb_vld;
        retire.pc        = wb_q.pc;
        retire.rd        = wb_q.rd;
        retire.writes_rd = wb_q.writes_rd;
    end

endmodule

`default_nettype wire

// File: hazard_pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "hz_defines.svh"

module hazard_pipe_top (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 instr_valid,
    input  wire hz_pkg::instr_word_u  instr_word,
    input  wire logic [`HZ_PC_W-1:0]  instr_pc,
    output logic                      stall,
    output hz_pkg::hazard_e           cause,
    output hz_pkg::retire_t           retire
);

    import hz_pkg::*;

    dec_instr_t id_slot;
    dec_instr_t ex_slot;
    dec_instr_t mem_slot;

    id_stage u_id_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr_word  (instr_word),
        .instr_pc    (instr_pc),
        .stall       (stall),
        .id_slot     (id_slot)
    );

    // decode holds and execute takes a bubble on the same stall level
    id_hazard u_id_hazard (
        .id_slot  (id_slot),
        .ex_slot  (ex_slot),
        .mem_slot (mem_slot),
        .stall    (stall),
        .cause    (cause)
    );

    back_pipe u_back_pipe (
        .clk      (clk),
        .rst_n    (rst_n),
        .id_slot  (id_slot),
        .stall    (stall),
        .ex_slot  (ex_slot),
        .mem_slot (mem_slot),
        .retire   (retire)
    );

endmodule

`default_nettype wire

// File: hz_defines.svh
`ifndef HZ_DEFINES_SVH
`define HZ_DEFINES_SVH

// register file index width
`define HZ_REG_AW 5

// program counter width
`define HZ_PC_W 64

// major opcodes the decoder recognises
`define HZ_OP_LOAD  7'b0000011
`define HZ_OP_STORE 7'b0100011
`define HZ_OP_IMM   7'b0010011
`define HZ_OP_REG   7'b0110011

// anything else decodes as a no-register instruction

`endif

// File: hz_pkg.sv
`default_nettype none

`include "hz_defines.svh"

package hz_pkg;

    // I-format view: load, op-imm
    typedef struct packed {
        logic [11:0]             imm;
        logic [`HZ_REG_AW-1:0]   rs1;
        logic [2:0]              funct3;
        logic [`HZ_REG_AW-1:0]   rd;
        logic [6:0]              opcode;
    } i_fmt_t;

    // S-format view: store, immediate split around rs2/rs1
    typedef struct packed {
        logic [6:0]              imm_hi;
        logic [`HZ_REG_AW-1:0]   rs2;
        logic [`HZ_REG_AW-1:0]   rs1;
        logic [2:0]              funct3;
        logic [4:0]              imm_lo;
        logic [6:0]              opcode;
    } s_fmt_t;

    typedef union packed {
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
    } instr_word_u;

    typedef enum logic [1:0] {
        cls_none,
        cls_alu,
        cls_load,
        cls_store
    } instr_class_e;

    typedef struct packed {
        logic                    valid;
        logic [`HZ_PC_W-1:0]     pc;
        instr_class_e            cls;
        logic [`HZ_REG_AW-1:0]   rs1;
        logic [`HZ_REG_AW-1:0]   rs2;
        logic [`HZ_REG_AW-1:0]   rd;
        logic                    uses_rs1;
        logic                    uses_rs2;
        logic                    writes_rd;
        // raw, sign not applied
        logic [11:0]             imm;
    } dec_instr_t;

    typedef enum logic [1:0] {
        hz_none,
        hz_load_ex,
        hz_load_mem,
        hz_store_load
    } hazard_e;

    typedef struct packed {
        logic                    valid;
        logic [`HZ_PC_W-1:0]     pc;
        logic [`HZ_REG_AW-1:0]   rd;
        logic                    writes_rd;
    } retire_t;

endpackage

`default_nettype wire

// File: id_hazard.sv
`timescale 1ns/1ps
`default_nettype none

module id_hazard (
    input  wire hz_pkg::dec_instr_t id_slot,
    input  wire hz_pkg::dec_instr_t ex_slot,
    input  wire hz_pkg::dec_instr_t mem_slot,
    output logic                    stall,
    output hz_pkg::hazard_e         cause
);

    import hz_pkg::*;

    logic load_ex_hit;
    logic load_mem_hit;
    logic store_load_hit;

    // does a load in a later slot produce a register the decode slot reads
    function automatic logic load_feeds(input dec_instr_t ld, input dec_instr_t dst);
        logic rs1_hit;
        logic rs2_hit;
        rs1_hit = dst.uses_rs1 && (dst.rs1 != '0) && (dst.rs1 == ld.rd);
        rs2_hit = dst.uses_rs2 && (dst.rs2 != '0) && (dst.rs2 == ld.rd);
        return ld.valid && (ld.cls == cls_load) && ld.writes_rd && (rs1_hit || rs2_hit);
    endfunction

    assign load_ex_hit  = load_feeds(ex_slot, id_slot);
    assign load_mem_hit = load_feeds(mem_slot, id_slot);

    // store then load to the same base and offset, keep them ordered
    assign store_load_hit = (id_slot.cls == cls_load)
                         && ex_slot.valid
                         && (ex_slot.cls == cls_store)
                         && (id_slot.rs1 == ex_slot.rs1)
                         && (id_slot.imm == ex_slot.imm);

    // priority: execute load, memory load, store-load
    always_comb begin
        cause = hz_none;
        if (id_slot.valid) begin
            if (load_ex_hit) begin
                cause = hz_load_ex;
            end else if (load_mem_hit) begin
                cause = hz_load_mem;
            end else if (store_load_hit) begin
                cause = hz_store_load;
            end
        end
    end

    // a load in writeback forwards, so nothing to check there
    assign stall = (cause != hz_none);

endmodule

`default_nettype wire

// File: id_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "hz_defines.svh"

module id_stage (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 instr_valid,
    input  wire hz_pkg::instr_word_u  instr_word,
    input  wire logic [`HZ_PC_W-1:0]  instr_pc,
    input  wire logic                 stall,
    output hz_pkg::dec_instr_t        id_slot
);

    import hz_pkg::*;

    logic                slot_vld;
    instr_word_u         word_q;
    logic [`HZ_PC_W-1:0] pc_q;

    // instruction class writes a destination register
    logic                rd_used;

    // slot occupancy, held while stalled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_vld <= 1'b0;
        end else if (!stall) begin
            slot_vld <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && instr_valid) begin
            word_q <= instr_word;
            pc_q   <= instr_pc;
        end
    end

    always_comb begin
        id_slot       = '0;
        rd_used       = 1'b0;
        id_slot.valid = slot_vld;
        id_slot.pc    = pc_q;

        case (word_q.i_fmt.opcode)
            `HZ_OP_LOAD: begin
                id_slot.cls      = cls_load;
                id_slot.uses_rs1 = 1'b1;
                rd_used          = 1'b1;
                id_slot.imm      = word_q.i_fmt.imm;
            end
            `HZ_OP_IMM: begin
                id_slot.cls      = cls_alu;
                id_slot.uses_rs1 = 1'b1;
                rd_used          = 1'b1;
                id_slot.imm      = word_q.i_fmt.imm;
            end
            `HZ_OP_STORE: begin
                id_slot.cls      = cls_store;
                id_slot.uses_rs1 = 1'b1;
                id_slot.uses_rs2 = 1'b1;
                id_slot.imm      = {word_q.s_fmt.imm_hi, word_q.s_fmt.imm_lo};
            end
            `HZ_OP_REG: begin
                id_slot.cls      = cls_alu;
                id_slot.uses_rs1 = 1'b1;
                id_slot.uses_rs2 = 1'b1;
                rd_used          = 1'b1;
            end
            default: begin
                id_slot.cls = cls_none;
            end
        endcase

        // unused register fields read as x0
        if (id_slot.uses_rs1) begin
            id_slot.rs1 = word_q.i_fmt.rs1;
        end
        if (id_slot.uses_rs2) begin
            id_slot.rs2 = word_q.s_fmt.rs2;
        end
        if (rd_used) begin
            id_slot.rd = word_q.i_fmt.rd;
        end
        // x0 is never a real destination
        id_slot.writes_rd = rd_used && (word_q.i_fmt.rd != '0);
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
hz_pkg.sv
id_stage.sv
id_hazard.sv
back_pipe.sv
hazard_pipe_top.sv
tb_clock_gen.sv
tb_hazard_pipe.sv

// File: tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset held over the first 3 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: tb_hazard_pipe.sv
`timescale 1ns/1ps
`default_nettype none

`include "hz_defines.svh"

module tb_hazard_pipe;

    import hz_pkg::*;

    localparam int NUM_INSTR = 400;
    // gaps plus at most 2 stall cycles per instruction, with drain margin
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 5;

    logic                clk;
    logic                rst_n;
    logic                instr_valid;
    instr_word_u         instr_word;
    logic [`HZ_PC_W-1:0] instr_pc;
    logic                stall;
    hazard_e             cause;
    hazard_e             prev_cause;
    retire_t             retire;

    // fields behind the word on the pins
    int                  in_kind;
    logic [4:0]          in_rs1;
    logic [4:0]          in_rs2;
    logic [4:0]          in_rd;
    logic [11:0]         in_imm;

    dec_instr_t          m_id;
    dec_instr_t          m_ex;
    dec_instr_t          m_mem;
    dec_instr_t          m_wb;
    hazard_e             m_cause;
    logic [31:0]         rand_state;
    logic [`HZ_PC_W-1:0] next_pc;
    logic [`HZ_PC_W-1:0] exp_retire_pc;
    int                  issued;
    int                  retired;
    int                  cycles;
    int                  mismatch_errs;
    int                  other_errs;
    int                  seen [0:3];

    tb_clock_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    hazard_pipe_top u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr_word  (instr_word),
        .instr_pc    (instr_pc),
        .stall       (stall),
        .cause       (cause),
        .retire      (retire)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int draw(input int n);
        rand_state = lcg_next(rand_state);
        return int'(rand_state[31:16]) % n;
    endfunction

    // kind: 0 load, 1 store, 2 op-imm, 3 op, 4 other opcode
    function automatic logic [31:0] encode(input int kind, input logic [4:0] rs1, rs2, rd,
                                           input logic [11:0] imm);
        case (kind)
            0: return {imm, rs1, 3'b011, rd, `HZ_OP_LOAD};
            1: return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], `HZ_OP_STORE};
            2: return {imm, rs1, 3'b000, rd, `HZ_OP_IMM};
            3: return {7'b0, rs2, rs1, 3'b000, rd, `HZ_OP_REG};
            default: return {imm, rs1, 3'b000, rd, 7'b0110111};
        endcase
    endfunction

    function automatic dec_instr_t expected_decode(input int kind, input logic [4:0] rs1, rs2, rd,
                                                   input logic [11:0] imm,
                                                   input logic [`HZ_PC_W-1:0] pc);
        dec_instr_t d;
        logic       has_rd;
        has_rd      = (kind == 0) || (kind == 2) || (kind == 3);
        d           = '0;
        d.valid     = 1'b1;
        d.pc        = pc;
        d.cls       = (kind == 0) ? cls_load : (kind == 1) ? cls_store :
                      (kind < 4) ? cls_alu : cls_none;
        d.uses_rs1  = (kind < 4);
        d.uses_rs2  = (kind == 1) || (kind == 3);
        d.rs1       = d.uses_rs1 ? rs1 : '0;
        d.rs2       = d.uses_rs2 ? rs2 : '0;
        d.rd        = has_rd ? rd : '0;
        d.writes_rd = has_rd && (rd != 5'd0);
        d.imm       = (kind <= 2) ? imm : '0;
        return d;
    endfunction

    // writes_rd already excludes x0
    function automatic logic load_result_needed(input dec_instr_t prod, input dec_instr_t cons);
        if (!prod.valid || prod.cls != cls_load || !prod.writes_rd)
            return 1'b0;
        return (cons.uses_rs1 && cons.rs1 == prod.rd) || (cons.uses_rs2 && cons.rs2 == prod.rd);
    endfunction

    function automatic hazard_e expected_hazard(input dec_instr_t id, ex, mem);
        if (!id.valid)
            return hz_none;
        if (load_result_needed(ex, id))
            return hz_load_ex;
        if (load_result_needed(mem, id))
            return hz_load_mem;
        if (id.cls == cls_load && ex.valid && ex.cls == cls_store && id.rs1 == ex.rs1
            && id.imm == ex.imm)
            return hz_store_load;
        return hz_none;
    endfunction

    // model advance, then the next word unless decode is stalled
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (rst_n) begin
            m_wb  = m_mem;
            m_mem = m_ex;
            if (m_cause != hz_none) begin
                m_ex = '0;
            end else begin
                m_ex = m_id;
                if (instr_valid)
                    m_id = expected_decode(in_kind, in_rs1, in_rs2, in_rd, in_imm, instr_pc);
                else
                    m_id = '0;
                if (issued < NUM_INSTR && draw(5) != 0) begin
                    in_kind = draw(5);
                    in_rs1  = 5'(draw(4));
                    in_rs2  = 5'(draw(4));
                    in_rd   = 5'(draw(4));
                    // low bits of 12'h7e3 alias x3 in unused register fields
                    in_imm  = (draw(2) != 0) ? 12'h7e3 : 12'h010;
                    instr_valid <= 1'b1;
                    instr_word  <= encode(in_kind, in_rs1, in_rs2, in_rd, in_imm);
                    instr_pc    <= next_pc;
                    next_pc = next_pc + 4;
                    issued  = issued + 1;
                end else begin
                    instr_valid <= 1'b0;
                end
            end
        end
    end

    always @(negedge clk) begin
        m_cause = expected_hazard(m_id, m_ex, m_mem);
        seen[int'(m_cause)] = seen[int'(m_cause)] + 1;
        if (stall !== (m_cause != hz_none)) begin
            mismatch_errs++;
            $display("mismatch at %0t: stall expected %0b actual %0b", $time,
                     m_cause != hz_none, stall);
        end
        if (cause !== m_cause) begin
            mismatch_errs++;
            $display("mismatch at %0t: cause expected %0d actual %0d", $time, m_cause, cause);
        end
        if (retire.valid !== m_wb.valid) begin
            mismatch_errs++;
            $display("mismatch at %0t: retire.valid expected %0b actual %0b", $time,
                     m_wb.valid, retire.valid);
        end else if (m_wb.valid) begin
            if (retire.pc !== m_wb.pc) begin
                mismatch_errs++;
                $display("mismatch at %0t: retire.pc expected %0h actual %0h", $time,
                         m_wb.pc, retire.pc);
            end
            if (retire.rd !== m_wb.rd) begin
                mismatch_errs++;
                $display("mismatch at %0t: retire.rd expected %0d actual %0d", $time,
                         m_wb.rd, retire.rd);
            end
            if (retire.writes_rd !== m_wb.writes_rd) begin
                mismatch_errs++;
                $display("mismatch at %0t: retire.writes_rd expected %0b actual %0b", $time,
                         m_wb.writes_rd, retire.writes_rd);
            end
        end
        if (retire.valid === 1'b1) begin
            if (retire.pc !== exp_retire_pc) begin
                other_errs++;
                $display("at %0t an instruction was lost, duplicated or retired out of order",
                         $time);
            end
            exp_retire_pc = exp_retire_pc + 4;
            retired = retired + 1;
        end
        // stall lengths, 2 for a load and 1 for store then load
        if (prev_cause == hz_load_ex && cause !== hz_load_mem) begin
            other_errs++;
            $display("at %0t a load in execute did not stall a second cycle", $time);
        end
        if ((prev_cause == hz_load_mem || prev_cause == hz_store_load) && stall === 1'b1) begin
            other_errs++;
            $display("at %0t a stall lasted longer than the hazard needs", $time);
        end
        prev_cause = cause;
    end

    initial begin
        instr_valid   = 1'b0;
        instr_word    = '0;
        instr_pc      = '0;
        in_kind       = 4;
        in_rs1        = '0;
        in_rs2        = '0;
        in_rd         = '0;
        in_imm        = '0;
        m_id          = '0;
        m_ex          = '0;
        m_mem         = '0;
        m_wb          = '0;
        m_cause       = hz_none;
        prev_cause    = hz_none;
        rand_state    = 32'h60fd_19cf;
        next_pc       = 64'h1000;
        exp_retire_pc = 64'h1000;
        issued        = 0;
        retired       = 0;
        cycles        = 0;
        mismatch_errs = 0;
        other_errs    = 0;
        for (int k = 0; k < 4; k++) begin
            seen[k] = 0;
        end

        while (retired < NUM_INSTR && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
        end
        if (cycles >= TIMEOUT_CYCLES) begin
            other_errs++;
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
        // drain so late or duplicate retires still get checked
        repeat (4) @(posedge clk);

        if (retired != NUM_INSTR) begin
            other_errs++;
            $display("%0d instructions retired instead of %0d", retired, NUM_INSTR);
        end
        for (int k = 1; k < 4; k++) begin
            if (seen[k] == 0) begin
                other_errs++;
                $display("hazard kind %0d never occurred in the run", k);
            end
        end
        $display("errors: %0d mismatch, %0d other; retired %0d of %0d in %0d cycles",
                 mismatch_errs, other_errs, retired, NUM_INSTR, cycles);
        if (mismatch_errs == 0 && other_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
